//--- source/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_mul  = 4'd10,
        alu_mulh = 4'd11
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef struct packed {
        rv32i_word i_imm;
        rv32i_word s_imm;
        rv32i_word b_imm;
        rv32i_word u_imm;
        rv32i_word j_imm;
    } imm_t;

    localparam rv32i_word reset_pc = 32'h4000_0000; // bubble pc
    localparam int unsigned mul_steps = 32;        // one step per multiplier bit

endpackage : rv32i_pkg

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [1:0] {
        reg_data = 2'b00,
        exe_fwd  = 2'b01,
        mem_fwd  = 2'b10,
        wb_fwd   = 2'b11
    } operand_fwd_sel_t;

    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmp_sel_t;

    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alu1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm = 3'd0,
        alu2_u_imm = 3'd1,
        alu2_b_imm = 3'd2,
        alu2_s_imm = 3'd3,
        alu2_j_imm = 3'd4,
        alu2_rs2   = 3'd5
    } alu2_sel_t;

    typedef struct packed {
        operand_fwd_sel_t       rs1_sel;
        operand_fwd_sel_t       rs2_sel;
        cmp_sel_t               cmp_sel;
        alu1_sel_t              alu1_sel;
        alu2_sel_t              alu2_sel;
        rv32i_pkg::branch_funct3 cmpop;
        rv32i_pkg::alu_ops      aluop;
    } exe_ctrl_t;

    typedef struct packed {
        logic       ld_reg;
        logic [4:0] rd_sel;
    } wb_ctrl_t;

    typedef struct packed {
        logic                 valid_commit;
        logic [63:0]          order_commit;
        rv32i_pkg::rv32i_word instruction;
        logic [4:0]           rs1_addr;
        logic [4:0]           rs2_addr;
        rv32i_pkg::rv32i_word rs1_data;
        rv32i_pkg::rv32i_word rs2_data;
        rv32i_pkg::rv32i_word pc_rdata;
        rv32i_pkg::rv32i_word pc_wdata;
        rv32i_pkg::rv32i_word mem_addr;
    } commit_t;

    typedef struct packed {
        exe_ctrl_t  exe;
        logic [3:0] mem; // mem stage fields, passed through untouched
        wb_ctrl_t   wb;
        commit_t    rvfi;
    } control_word_t;

    // word sent downstream in every cycle without a completing instruction
    localparam control_word_t bubble_word = '{
        exe: '{rs1_sel: reg_data, rs2_sel: reg_data, cmp_sel: cmp_rs2,
               alu1_sel: alu1_rs1, alu2_sel: alu2_i_imm,
               cmpop: rv32i_pkg::beq, aluop: rv32i_pkg::alu_add},
        mem: 4'b0000,
        wb: '{ld_reg: 1'b0, rd_sel: 5'd0},
        rvfi: '{pc_rdata: rv32i_pkg::reset_pc, default: '0}
    };

endpackage : ctrl_pkg

`default_nettype wire

//--- source/branch_cmp.sv
`timescale 1ns/10ps
`default_nettype none

module branch_cmp (
    input  rv32i_pkg::branch_funct3 cmpop_i,
    input  rv32i_pkg::rv32i_word    a_i,
    input  rv32i_pkg::rv32i_word    b_i,
    output logic                    br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            rv32i_pkg::beq:  br_en_o = eq;
            rv32i_pkg::bne:  br_en_o = !eq;
            rv32i_pkg::blt:  br_en_o = lt_s;
            rv32i_pkg::bge:  br_en_o = !lt_s;
            rv32i_pkg::bltu: br_en_o = lt_u;
            rv32i_pkg::bgeu: br_en_o = !lt_u;
            default:         br_en_o = 1'b0; // reserved funct3 never taken
        endcase
    end

endmodule : branch_cmp

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic                 clk,
    input  logic                 rst,
    input  rv32i_pkg::alu_ops    aluop_i,
    input  logic                 start_i,
    input  rv32i_pkg::rv32i_word a_i,
    input  rv32i_pkg::rv32i_word b_i,
    output rv32i_pkg::rv32i_word f_o,
    output logic                 done_o
);

    localparam int unsigned CNT_W = $clog2(rv32i_pkg::mul_steps + 1);

    logic                 is_mul;
    logic                 is_mulh;
    logic                 mul_load;
    logic                 busy;
    logic [CNT_W-1:0]     count;
    logic [63:0]          prod;       // {partial high, remaining multiplier}
    logic [63:0]          prod_res;
    logic [32:0]          partial;
    rv32i_pkg::rv32i_word mcand;
    rv32i_pkg::rv32i_word mag_a;
    rv32i_pkg::rv32i_word mag_b;
    logic                 neg;
    logic [4:0]           shamt;

    assign is_mulh  = (aluop_i == rv32i_pkg::alu_mulh);
    assign is_mul   = (aluop_i == rv32i_pkg::alu_mul) || is_mulh;
    assign mul_load = start_i && is_mul;
    assign shamt    = b_i[4:0];

    // sign-magnitude for mulh, raw operands for mul
    assign mag_a = (is_mulh && a_i[31]) ? -a_i : a_i;
    assign mag_b = (is_mulh && b_i[31]) ? -b_i : b_i;

    assign partial  = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);
    assign prod_res = neg ? -prod : prod;

    // low while a multiply is starting or stepping
    assign done_o = !busy && !mul_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (mul_load) begin
            busy  <= 1'b1;
            count <= CNT_W'(rv32i_pkg::mul_steps);
        end else if (busy) begin
            count <= count - 1'b1;
            if (count == CNT_W'(1)) begin
                busy <= 1'b0; // last shift-add step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_load) begin
            mcand <= mag_a;
            prod  <= {32'd0, mag_b};
            neg   <= is_mulh && (a_i[31] ^ b_i[31]);
        end else if (busy) begin
            prod <= {partial, prod[31:1]};
        end
    end

    always_comb begin
        case (aluop_i)
            rv32i_pkg::alu_add:  f_o = a_i + b_i;
            rv32i_pkg::alu_sub:  f_o = a_i - b_i;
            rv32i_pkg::alu_sll:  f_o = a_i << shamt;
            rv32i_pkg::alu_slt:  f_o = {31'd0, $signed(a_i) < $signed(b_i)};
            rv32i_pkg::alu_sltu: f_o = {31'd0, a_i < b_i};
            rv32i_pkg::alu_xor:  f_o = a_i ^ b_i;
            rv32i_pkg::alu_srl:  f_o = a_i >> shamt;
            rv32i_pkg::alu_sra:  f_o = $signed(a_i) >>> shamt;
            rv32i_pkg::alu_or:   f_o = a_i | b_i;
            rv32i_pkg::alu_and:  f_o = a_i & b_i;
            rv32i_pkg::alu_mul:  f_o = prod_res[31:0];
            rv32i_pkg::alu_mulh: f_o = prod_res[63:32];
            default:             f_o = a_i + b_i;
        endcase
    end

endmodule : alu

`default_nettype wire

//--- source/de_exe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module de_exe_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::control_word_t in_word_i,
    input  rv32i_pkg::rv32i_opcode  opcode_i,
    input  rv32i_pkg::imm_t         imm_i,
    input  logic                    in_valid_i,
    input  logic                    done_i,
    input  logic                    out_ready_i,
    output ctrl_pkg::control_word_t word_o,
    output rv32i_pkg::rv32i_opcode  opcode_o,
    output rv32i_pkg::imm_t         imm_o,
    output logic                    held_valid_o,
    output logic                    in_ready_o
);

    logic load;
    logic complete;

    assign complete   = held_valid_o && done_i && out_ready_i;
    assign in_ready_o = !held_valid_o || complete; // empty or leaving this cycle
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid_o <= 1'b0;
        end else if (load) begin
            held_valid_o <= 1'b1;
        end else if (complete) begin
            held_valid_o <= 1'b0; // drained, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_o   <= in_word_i;
            opcode_o <= opcode_i;
            imm_o    <= imm_i;
        end
    end

endmodule : de_exe_reg

`default_nettype wire

//--- source/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::control_word_t word_i,
    input  rv32i_pkg::rv32i_opcode  opcode_i,
    input  rv32i_pkg::imm_t         imm_i,
    input  logic                    held_valid_i,
    input  logic                    out_ready_i,
    input  rv32i_pkg::rv32i_word    exe_fwd_i,
    input  rv32i_pkg::rv32i_word    mem_fwd_i,
    input  rv32i_pkg::rv32i_word    wb_fwd_i,
    output rv32i_pkg::rv32i_word    alu_o,
    output logic                    br_en_o,
    output rv32i_pkg::rv32i_word    rs2_o,
    output logic                    done_o,
    output ctrl_pkg::control_word_t out_word_o
);

    rv32i_pkg::rv32i_word rs1_fwd;
    rv32i_pkg::rv32i_word rs2_fwd;
    rv32i_pkg::rv32i_word cmp_b;
    rv32i_pkg::rv32i_word alu_a;
    rv32i_pkg::rv32i_word alu_b;
    logic [63:0]          prev_order;
    logic                 alu_start;
    logic                 complete;

    assign rs2_o     = rs2_fwd;
    assign alu_start = held_valid_i && (word_i.rvfi.order_commit != prev_order);
    assign complete  = held_valid_i && done_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_order <= '1; // no order seen yet
        end else if (held_valid_i) begin
            prev_order <= word_i.rvfi.order_commit;
        end
    end

    always_comb begin
        unique case (word_i.exe.rs1_sel)
            ctrl_pkg::reg_data: rs1_fwd = word_i.rvfi.rs1_data;
            ctrl_pkg::exe_fwd:  rs1_fwd = exe_fwd_i;
            ctrl_pkg::mem_fwd:  rs1_fwd = mem_fwd_i;
            ctrl_pkg::wb_fwd:   rs1_fwd = wb_fwd_i;
        endcase
        unique case (word_i.exe.rs2_sel)
            ctrl_pkg::reg_data: rs2_fwd = word_i.rvfi.rs2_data;
            ctrl_pkg::exe_fwd:  rs2_fwd = exe_fwd_i;
            ctrl_pkg::mem_fwd:  rs2_fwd = mem_fwd_i;
            ctrl_pkg::wb_fwd:   rs2_fwd = wb_fwd_i;
        endcase
        cmp_b = (word_i.exe.cmp_sel == ctrl_pkg::cmp_i_imm) ? imm_i.i_imm : rs2_fwd;
        alu_a = (word_i.exe.alu1_sel == ctrl_pkg::alu1_pc) ? word_i.rvfi.pc_rdata : rs1_fwd;
        case (word_i.exe.alu2_sel)
            ctrl_pkg::alu2_i_imm: alu_b = imm_i.i_imm;
            ctrl_pkg::alu2_u_imm: alu_b = imm_i.u_imm;
            ctrl_pkg::alu2_b_imm: alu_b = imm_i.b_imm;
            ctrl_pkg::alu2_s_imm: alu_b = imm_i.s_imm;
            ctrl_pkg::alu2_j_imm: alu_b = imm_i.j_imm;
            default:              alu_b = rs2_fwd;
        endcase
    end

    alu u_alu (
        .clk     (clk),
        .rst     (rst),
        .aluop_i (word_i.exe.aluop),
        .start_i (alu_start),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .f_o     (alu_o),
        .done_o  (done_o)
    );

    branch_cmp u_branch_cmp (
        .cmpop_i (word_i.exe.cmpop),
        .a_i     (rs1_fwd),
        .b_i     (cmp_b),
        .br_en_o (br_en_o)
    );

    always_comb begin
        out_word_o = ctrl_pkg::bubble_word;
        if (complete) begin
            out_word_o               = word_i;
            out_word_o.rvfi.rs1_data = rs1_fwd; // forwarded operands go to commit
            out_word_o.rvfi.rs2_data = rs2_fwd;
            if ((br_en_o && opcode_i == rv32i_pkg::op_br) || opcode_i == rv32i_pkg::op_jal) begin
                out_word_o.rvfi.pc_wdata = alu_o;
            end else if (opcode_i == rv32i_pkg::op_jalr) begin
                out_word_o.rvfi.pc_wdata = {alu_o[31:1], 1'b0};
            end else begin
                out_word_o.rvfi.pc_wdata = word_i.rvfi.pc_rdata + 32'd4;
            end
        end
    end

endmodule : exe_stage

`default_nettype wire

//--- source/exe_top.sv
`timescale 1ns/10ps
`default_nettype none

module exe_top (
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_pkg::control_word_t in_word_i,
    input  rv32i_pkg::rv32i_opcode  opcode_i,
    input  rv32i_pkg::imm_t         imm_i,
    input  logic                    in_valid_i,
    input  rv32i_pkg::rv32i_word    exe_fwd_i,
    input  rv32i_pkg::rv32i_word    mem_fwd_i,
    input  rv32i_pkg::rv32i_word    wb_fwd_i,
    input  logic                    out_ready_i,
    output ctrl_pkg::control_word_t out_word_o,
    output rv32i_pkg::rv32i_word    alu_o,
    output logic                    br_en_o,
    output rv32i_pkg::rv32i_word    rs2_o,
    output logic                    in_ready_o
);

    ctrl_pkg::control_word_t held_word;
    rv32i_pkg::rv32i_opcode  held_opcode;
    rv32i_pkg::imm_t         held_imm;
    logic                    held_valid;
    logic                    exe_done;

    de_exe_reg u_de_exe_reg (
        .clk          (clk),
        .rst          (rst),
        .in_word_i    (in_word_i),
        .opcode_i     (opcode_i),
        .imm_i        (imm_i),
        .in_valid_i   (in_valid_i),
        .done_i       (exe_done),
        .out_ready_i  (out_ready_i),
        .word_o       (held_word),
        .opcode_o     (held_opcode),
        .imm_o        (held_imm),
        .held_valid_o (held_valid),
        .in_ready_o   (in_ready_o)
    );

    exe_stage u_exe_stage (
        .clk          (clk),
        .rst          (rst),
        .word_i       (held_word),
        .opcode_i     (held_opcode),
        .imm_i        (held_imm),
        .held_valid_i (held_valid),
        .out_ready_i  (out_ready_i),
        .exe_fwd_i    (exe_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .alu_o        (alu_o),
        .br_en_o      (br_en_o),
        .rs2_o        (rs2_o),
        .done_o       (exe_done),
        .out_word_o   (out_word_o)
    );

endmodule : exe_top

`default_nettype wire

//--- test/exe_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exe_top_tb;

    typedef struct packed {
        logic [127:0]         name;
        logic [6:0]           op;
        logic [1:0]           rs1s;
        logic [1:0]           rs2s;
        logic                 cmps;
        logic                 a1s;
        logic [2:0]           a2s;
        logic [2:0]           cmpop;
        logic [3:0]           aluop;
        rv32i_pkg::rv32i_word rs1, rs2, efw, mfw, wfw;
        rv32i_pkg::rv32i_word i_imm, s_imm, b_imm, u_imm, j_imm, pc;
        logic [63:0]          ord;
        logic                 rdy;
        rv32i_pkg::rv32i_word exp_alu;
        logic                 exp_br;
        rv32i_pkg::rv32i_word exp_pcw;
    } vec_t;

    logic                    clk = 1'b0;
    logic                    rst;
    ctrl_pkg::control_word_t in_word_i;
    rv32i_pkg::rv32i_opcode  opcode_i;
    rv32i_pkg::imm_t         imm_i;
    logic                    in_valid_i;
    rv32i_pkg::rv32i_word    exe_fwd_i;
    rv32i_pkg::rv32i_word    mem_fwd_i;
    rv32i_pkg::rv32i_word    wb_fwd_i;
    logic                    out_ready_i;
    ctrl_pkg::control_word_t out_word_o;
    rv32i_pkg::rv32i_word    alu_o;
    logic                    br_en_o;
    rv32i_pkg::rv32i_word    rs2_o;
    logic                    in_ready_o;

    vec_t vecs [64];
    int   nvec = 0;
    int   cycles = 0;
    int   limit = 20; // raised once the vectors are known

    exe_top UUT (
        .clk         (clk),
        .rst         (rst),
        .in_word_i   (in_word_i),
        .opcode_i    (opcode_i),
        .imm_i       (imm_i),
        .in_valid_i  (in_valid_i),
        .exe_fwd_i   (exe_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .wb_fwd_i    (wb_fwd_i),
        .out_ready_i (out_ready_i),
        .out_word_o  (out_word_o),
        .alu_o       (alu_o),
        .br_en_o     (br_en_o),
        .rs2_o       (rs2_o),
        .in_ready_o  (in_ready_o)
    );

    always #50 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            stop_with_error("timeout: the DUT stopped making progress");
        end
    end

    task automatic check_word(input logic [127:0] tname, input string what,
                              input rv32i_pkg::rv32i_word exp, input rv32i_pkg::rv32i_word act);
        if (exp !== act) begin
            stop_with_error($sformatf("[FAIL] %0s %s: expected %h, actual %h",
                                      tname, what, exp, act));
        end
    endtask

    task automatic check_bit(input logic [127:0] tname, input string what,
                             input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_error($sformatf("[FAIL] %0s %s: expected %b, actual %b",
                                      tname, what, exp, act));
        end
    endtask

    task automatic check_commit(input logic [127:0] tname, input string what,
                                input ctrl_pkg::commit_t exp, input ctrl_pkg::commit_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("[FAIL] %0s %s: expected %h, actual %h",
                                      tname, what, exp, act));
        end
    endtask

    task automatic check_control(input logic [127:0] tname, input string what,
                                 input ctrl_pkg::control_word_t exp,
                                 input ctrl_pkg::control_word_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("[FAIL] %0s %s: expected %h, actual %h",
                                      tname, what, exp, act));
        end
    endtask

    // forwarding mux as the stage is meant to behave
    function automatic rv32i_pkg::rv32i_word fwd_value(input logic [1:0] sel, input vec_t v,
                                                       input rv32i_pkg::rv32i_word reg_val);
        case (sel)
            2'd1:    return v.efw;
            2'd2:    return v.mfw;
            2'd3:    return v.wfw;
            default: return reg_val;
        endcase
    endfunction

    task automatic check_idle(input logic [127:0] tname);
        ctrl_pkg::control_word_t bubble;
        bubble               = '0;
        bubble.exe.rs1_sel   = ctrl_pkg::reg_data;
        bubble.exe.rs2_sel   = ctrl_pkg::reg_data;
        bubble.exe.cmp_sel   = ctrl_pkg::cmp_rs2;
        bubble.exe.alu1_sel  = ctrl_pkg::alu1_rs1;
        bubble.exe.alu2_sel  = ctrl_pkg::alu2_i_imm;
        bubble.exe.cmpop     = rv32i_pkg::beq;
        bubble.exe.aluop     = rv32i_pkg::alu_add;
        bubble.rvfi.pc_rdata = rv32i_pkg::reset_pc;
        check_bit(tname, "idle valid_commit", 1'b0, out_word_o.rvfi.valid_commit);
        check_control(tname, "idle word", bubble, out_word_o);
        check_bit(tname, "idle in_ready_o", 1'b1, in_ready_o);
    endtask

    task automatic read_vectors();
        int fd;
        int n;
        string line;
        logic [127:0] nm;
        logic [6:0] op;
        logic [1:0] s1, s2;
        logic cs, a1, rdy, ebr;
        logic [2:0] a2, cop;
        logic [3:0] aop;
        rv32i_pkg::rv32i_word r1, r2, ef, mf, wf, ii, si, bi, ui, ji, pc, ealu, epcw;
        logic [63:0] ord;
        fd = $fopen("test/exe_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open test/exe_vectors.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n < 2 || line.getc(0) == 8'h23) begin
                continue; // blank or comment line
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        nm, op, s1, s2, cs, a1, a2, cop, aop, r1, r2, ef, mf, wf,
                        ii, si, bi, ui, ji, pc, ord, rdy, ealu, ebr, epcw);
            if (n != 25) begin
                stop_with_error($sformatf("malformed vector line: %s", line));
            end
            vecs[nvec] = '{nm, op, s1, s2, cs, a1, a2, cop, aop, r1, r2, ef, mf, wf,
                           ii, si, bi, ui, ji, pc, ord, rdy, ealu, ebr, epcw};
            nvec++;
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input vec_t v);
        int idle;
        int lat;
        int exp_lat;
        ctrl_pkg::commit_t exp;
        ctrl_pkg::control_word_t exp_word;
        idle = int'($urandom % 3);
        repeat (idle) begin
            @(negedge clk);
            check_idle(v.name);
        end
        @(negedge clk);
        check_idle(v.name);
        in_word_i                   = '0;
        in_word_i.exe.rs1_sel       = ctrl_pkg::operand_fwd_sel_t'(v.rs1s);
        in_word_i.exe.rs2_sel       = ctrl_pkg::operand_fwd_sel_t'(v.rs2s);
        in_word_i.exe.cmp_sel       = ctrl_pkg::cmp_sel_t'(v.cmps);
        in_word_i.exe.alu1_sel      = ctrl_pkg::alu1_sel_t'(v.a1s);
        in_word_i.exe.alu2_sel      = ctrl_pkg::alu2_sel_t'(v.a2s);
        in_word_i.exe.cmpop         = rv32i_pkg::branch_funct3'(v.cmpop);
        in_word_i.exe.aluop         = rv32i_pkg::alu_ops'(v.aluop);
        in_word_i.mem               = 4'($urandom);
        in_word_i.wb.ld_reg         = 1'b1;
        in_word_i.wb.rd_sel         = 5'($urandom);
        in_word_i.rvfi.valid_commit = 1'b1;
        in_word_i.rvfi.order_commit = v.ord;
        in_word_i.rvfi.instruction  = $urandom;
        in_word_i.rvfi.rs1_addr     = 5'($urandom);
        in_word_i.rvfi.rs2_addr     = 5'($urandom);
        in_word_i.rvfi.rs1_data     = v.rs1;
        in_word_i.rvfi.rs2_data     = v.rs2;
        in_word_i.rvfi.pc_rdata     = v.pc;
        in_word_i.rvfi.mem_addr     = $urandom;
        opcode_i    = rv32i_pkg::rv32i_opcode'(v.op);
        imm_i       = '{i_imm: v.i_imm, s_imm: v.s_imm, b_imm: v.b_imm,
                        u_imm: v.u_imm, j_imm: v.j_imm};
        exe_fwd_i   = v.efw;
        mem_fwd_i   = v.mfw;
        wb_fwd_i    = v.wfw;
        out_ready_i = v.rdy;
        in_valid_i  = 1'b1;
        exp_lat = (v.aluop >= 4'd10) ? 33 : 0; // multiplies take 33 cycles
        if (!v.rdy) begin
            exp_lat = exp_lat + 3; // held back three cycles past done
        end
        @(negedge clk);
        in_valid_i = 1'b0; // captured at the last rising edge
        lat = 0;
        while (out_word_o.rvfi.valid_commit !== 1'b1) begin
            check_bit(v.name, "busy in_ready_o", 1'b0, in_ready_o);
            if (out_ready_i !== 1'b1 && lat >= exp_lat) begin
                out_ready_i = 1'b1; // mem stage takes the result this cycle
                #1;
            end else begin
                @(negedge clk);
                lat++;
            end
        end
        if (out_ready_i !== 1'b1) begin
            stop_with_error("commit appeared while out_ready_i was low");
        end
        if (lat != exp_lat) begin
            stop_with_error($sformatf("[FAIL] %0s latency: expected %0d, actual %0d",
                                      v.name, exp_lat, lat));
        end
        exp          = in_word_i.rvfi;
        exp.rs1_data = fwd_value(v.rs1s, v, v.rs1);
        exp.rs2_data = fwd_value(v.rs2s, v, v.rs2);
        exp.pc_wdata = v.exp_pcw;
        exp_word      = in_word_i;
        exp_word.rvfi = exp;
        check_word(v.name, "alu_o", v.exp_alu, alu_o);
        check_bit(v.name, "br_en_o", v.exp_br, br_en_o);
        check_word(v.name, "rs2_o", exp.rs2_data, rs2_o);
        check_commit(v.name, "commit", exp, out_word_o.rvfi);
        check_control(v.name, "out word", exp_word, out_word_o);
        check_bit(v.name, "done in_ready_o", 1'b1, in_ready_o);
        @(negedge clk);
        check_idle(v.name); // result reported only once
    endtask

    initial begin
        rst         = 1'b1;
        in_word_i   = '0;
        opcode_i    = rv32i_pkg::op_imm;
        imm_i       = '0;
        in_valid_i  = 1'b0;
        exe_fwd_i   = '0;
        mem_fwd_i   = '0;
        wb_fwd_i    = '0;
        out_ready_i = 1'b1;
        void'($urandom(73895));
        read_vectors();
        if (nvec == 0) begin
            stop_with_error("no vectors found in test/exe_vectors.txt");
        end
        limit = nvec * 40 + 20;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_idle("reset");
        for (int i = 0; i < nvec; i++) begin
            run_vector(vecs[i]);
        end
        $display("No errors");
        $finish;
    end

endmodule : exe_top_tb

`default_nettype wire

//--- test/exe_vectors.txt
# name op rs1_sel rs2_sel cmp_sel alu1_sel alu2_sel cmpop aluop rs1 rs2 exe_fwd mem_fwd wb_fwd
# i_imm s_imm b_imm u_imm j_imm pc order out_ready, then expected alu br_en pc_wdata (all hex)
add_rr 33 0 0 0 0 5 0 0 5 7 100 200 300 10 20 30 12000 40 1000 1 1 c 0 1004
sub_rr 33 0 0 0 0 5 0 1 5 7 100 200 300 10 20 30 12000 40 1000 2 1 fffffffe 0 1004
sll_rr 33 0 0 0 0 5 0 2 3 4 100 200 300 10 20 30 12000 40 1000 3 1 30 0 1004
slt_rr 33 0 0 0 0 5 0 3 fffffffe 1 100 200 300 10 20 30 12000 40 1000 4 1 1 0 1004
sltu_rr 33 0 0 0 0 5 0 4 fffffffe 1 100 200 300 10 20 30 12000 40 1000 5 1 0 0 1004
xor_rr 33 0 0 0 0 5 0 5 ff00 ff0 100 200 300 10 20 30 12000 40 1000 6 1 f0f0 0 1004
srl_rr 33 0 0 0 0 5 0 6 80000000 4 100 200 300 10 20 30 12000 40 1000 7 1 8000000 0 1004
sra_rr 33 0 0 0 0 5 0 7 80000000 4 100 200 300 10 20 30 12000 40 1000 8 1 f8000000 0 1004
or_rr 33 0 0 0 0 5 0 8 f0 f 100 200 300 10 20 30 12000 40 1000 9 1 ff 0 1004
and_rr 33 0 0 0 0 5 0 9 f0 3c 100 200 300 10 20 30 12000 40 1000 a 1 30 0 1004
addi 13 0 0 0 0 0 0 0 5 7 100 200 300 10 20 30 12000 40 1000 b 1 15 0 1004
slti 13 0 0 0 0 0 0 3 fffffff0 7 100 200 300 10 20 30 12000 40 1000 c 1 1 0 1004
andi_stall 13 0 0 0 0 0 0 9 ff 7 100 200 300 10 20 30 12000 40 1000 d 0 10 0 1004
srai 13 0 0 0 0 0 0 7 f0000000 7 100 200 300 4 20 30 12000 40 1000 e 1 ff000000 0 1004
fwd_ex 33 1 1 0 0 5 0 0 5 7 100 200 300 10 20 30 12000 40 1000 f 1 200 1 1004
fwd_mem 33 2 3 0 0 5 0 0 5 7 100 200 300 10 20 30 12000 40 1000 10 1 500 0 1004
fwd_wb 33 3 0 0 0 5 0 0 5 7 100 200 300 10 20 30 12000 40 1000 11 1 307 0 1004
lui 37 0 0 0 0 1 0 0 0 7 100 200 300 10 20 30 12000 40 1000 12 1 12000 0 1004
auipc 17 0 0 0 1 1 0 0 5 7 100 200 300 10 20 30 12000 40 1000 13 1 13000 0 1004
store 23 0 0 0 0 3 0 0 5 7 100 200 300 10 20 30 12000 40 1000 14 1 25 0 1004
load 03 0 0 0 0 0 0 0 8 7 100 200 300 10 20 30 12000 40 1000 15 1 18 0 1004
beq_t 63 0 0 0 1 2 0 0 9 9 100 200 300 10 20 30 12000 40 1000 16 1 1030 1 1030
bne_nt 63 0 0 0 1 2 1 0 9 9 100 200 300 10 20 30 12000 40 1000 17 1 1030 0 1004
blt_t 63 0 0 0 1 2 4 0 ffffffff 1 100 200 300 10 20 30 12000 40 1000 18 1 1030 1 1030
bge_nt 63 0 0 0 1 2 5 0 ffffffff 1 100 200 300 10 20 30 12000 40 1000 19 1 1030 0 1004
bltu_nt 63 0 0 0 1 2 6 0 ffffffff 1 100 200 300 10 20 30 12000 40 1000 1a 1 1030 0 1004
bgeu_t 63 0 0 0 1 2 7 0 ffffffff 1 100 200 300 10 20 30 12000 40 1000 1b 1 1030 1 1030
cmp_imm 13 0 0 1 0 0 0 0 10 7 100 200 300 10 20 30 12000 40 1000 1c 1 20 1 1004
jal 6f 0 0 0 1 4 0 0 5 7 100 200 300 10 20 30 12000 40 1000 1d 1 1040 0 1040
jalr 67 0 0 0 0 0 0 0 2001 7 100 200 300 10 20 30 12000 40 1000 1e 1 2011 0 2010
mul 33 0 0 0 0 5 0 a 12345 1000 100 200 300 10 20 30 12000 40 1000 1f 1 12345000 0 1004
mul_neg 33 0 0 0 0 5 0 a fffffffd 7 100 200 300 10 20 30 12000 40 1000 20 1 ffffffeb 0 1004
mulh_neg 33 0 0 0 0 5 0 b fffffffd 7 100 200 300 10 20 30 12000 40 1000 21 1 ffffffff 0 1004
mulh_big 33 0 0 0 0 5 0 b 40000000 40000000 100 200 300 10 20 30 12000 40 1000 22 1 10000000 1 1004
mulh_max 33 0 0 0 0 5 0 b 7fffffff 7fffffff 100 200 300 10 20 30 12000 40 1000 23 1 3fffffff 1 1004
mulh_stall 33 0 0 0 0 5 0 b 3 5 100 200 300 10 20 30 12000 40 1000 24 0 0 0 1004

//--- filelist.f
source/rv32i_pkg.sv
source/ctrl_pkg.sv
source/branch_cmp.sv
source/alu.sv
source/de_exe_reg.sv
source/exe_stage.sv
source/exe_top.sv
test/exe_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass message in the log
rm -f sim.log
verilator --binary --timing -sv -Wno-fatal -f filelist.f --top-module exe_top_tb \
    -o exe_sim > build.log 2>&1 \
    && ./obj_dir/exe_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
